// File: common/aes_ctr_pkg.sv
// AES CTR block counter package
// Counter and slice sizes, FSM state and opcode encodings,
// request and response structs shared by the counter blocks

`default_nettype none

package aes_ctr_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Full counter width
  localparam int unsigned CtrWidth      = 128;
  // Bits handled per increment step
  localparam int unsigned SliceSizeCtr  = 16;
  localparam int unsigned NumSlicesCtr  = CtrWidth / SliceSizeCtr;
  localparam int unsigned SliceIdxWidth = $clog2(NumSlicesCtr);

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Counter FSM states, pairwise distance of at least three bits
  typedef enum logic [5:0] {
    CTR_IDLE  = 6'b011010,
    CTR_INCR  = 6'b100011,
    CTR_ERROR = 6'b110101
  } aes_ctr_e;

  // Requester opcodes, 2'b00 and 2'b11 are illegal
  typedef enum logic [1:0] {
    CTR_OP_LOAD = 2'b01,
    CTR_OP_INCR = 2'b10
  } ctr_op_e;

  // Request from the requester side
  typedef struct packed {
    ctr_op_e             op;
    logic [CtrWidth-1:0] data;
  } ctr_req_t;

  // Response back to the requester
  typedef struct packed {
    logic [CtrWidth-1:0] ctr;
    logic                alert;
  } ctr_rsp_t;

endpackage

`default_nettype wire

// File: aes_ctr/aes_ctr_fsm.sv
// AES CTR increment FSM
// Adds one to the counter a slice per cycle, LSB slice first,
// carrying between slices; terminal error state raises the alert

`timescale 1ns/1ns
`default_nettype none

module aes_ctr_fsm (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  // Increment request and ready back to the front end
  input  logic                                  incr_i,
  output logic                                  ready_o,
  input  logic                                  incr_err_i,
  output logic                                  alert_o,

  // Slice access into counter storage
  output logic [aes_ctr_pkg::SliceIdxWidth-1:0] ctr_slice_idx_o,
  input  logic [aes_ctr_pkg::SliceSizeCtr-1:0]  ctr_slice_i,
  output logic [aes_ctr_pkg::SliceSizeCtr-1:0]  ctr_slice_o,
  output logic                                  ctr_we_o
);

  import aes_ctr_pkg::*;

  aes_ctr_e                 ctr_state_d, ctr_state_q;
  logic [SliceIdxWidth-1:0] ctr_slice_idx_d, ctr_slice_idx_q;
  logic                     ctr_carry_d, ctr_carry_q;
  // One extra bit for the carry out
  logic [SliceSizeCtr:0]    ctr_value;

  ////////////////////////////////////////
  // Slice adder
  ////////////////////////////////////////

  assign ctr_value   = {1'b0, ctr_slice_i} + {{SliceSizeCtr{1'b0}}, ctr_carry_q};
  assign ctr_slice_o = ctr_value[SliceSizeCtr-1:0];

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    // Output defaults
    ready_o         = 1'b0;
    ctr_we_o        = 1'b0;
    alert_o         = 1'b0;

    // Hold by default
    ctr_state_d     = ctr_state_q;
    ctr_slice_idx_d = ctr_slice_idx_q;
    ctr_carry_d     = ctr_carry_q;

    case (ctr_state_q)
      CTR_IDLE: begin
        ready_o = 1'b1;
        if (incr_i) begin
          // Start at slice 0 with carry in of one
          ctr_slice_idx_d = '0;
          ctr_carry_d     = 1'b1;
          ctr_state_d     = CTR_INCR;
        end
      end

      CTR_INCR: begin
        // Write back current slice, keep carry out
        ctr_we_o        = 1'b1;
        ctr_carry_d     = ctr_value[SliceSizeCtr];
        ctr_slice_idx_d = ctr_slice_idx_q + SliceIdxWidth'(1);
        // Last slice done
        if (ctr_slice_idx_q == SliceIdxWidth'(NumSlicesCtr - 1)) begin
          ctr_state_d = CTR_IDLE;
        end
      end

      CTR_ERROR: begin
        // Terminal, left only by reset
        alert_o = 1'b1;
      end

      default: begin
        // Unknown encoding, treat as fault
        ctr_state_d = CTR_ERROR;
        alert_o     = 1'b1;
      end
    endcase

    // Error input overrides everything
    if (incr_err_i) begin
      ctr_state_d = CTR_ERROR;
    end
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctr_state_q     <= CTR_IDLE;
      ctr_slice_idx_q <= '0;
      ctr_carry_q     <= 1'b0;
    end else begin
      ctr_state_q     <= ctr_state_d;
      ctr_slice_idx_q <= ctr_slice_idx_d;
      ctr_carry_q     <= ctr_carry_d;
    end
  end

  // Slice index straight from the flop
  assign ctr_slice_idx_o = ctr_slice_idx_q;

endmodule

`default_nettype wire

// File: aes_ctr/aes_ctr_slices.sv
// AES CTR counter storage
// 128-bit counter kept as eight 16-bit slices, with full-width
// load, indexed slice write and combinational reads

`timescale 1ns/1ns
`default_nettype none

module aes_ctr_slices (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  // Full-width load
  input  logic                                  load_i,
  input  logic [aes_ctr_pkg::CtrWidth-1:0]      load_data_i,

  // Indexed slice access
  input  logic [aes_ctr_pkg::SliceIdxWidth-1:0] slice_idx_i,
  input  logic                                  slice_we_i,
  input  logic [aes_ctr_pkg::SliceSizeCtr-1:0]  slice_i,
  output logic [aes_ctr_pkg::SliceSizeCtr-1:0]  slice_o,

  // Whole counter
  output logic [aes_ctr_pkg::CtrWidth-1:0]      ctr_o
);

  import aes_ctr_pkg::*;

  // Slice 0 holds the least significant bits
  logic [NumSlicesCtr-1:0][SliceSizeCtr-1:0] ctr_q;

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctr_q <= '0;
    end else if (load_i) begin
      // Load wins over a slice write
      ctr_q <= load_data_i;
    end else if (slice_we_i) begin
      ctr_q[slice_idx_i] <= slice_i;
    end
  end

  ////////////////////////////////////////
  // Read side
  ////////////////////////////////////////

  // Addressed slice back to the FSM adder
  assign slice_o = ctr_q[slice_idx_i];

  // Flattened counter
  assign ctr_o   = ctr_q;

endmodule

`default_nettype wire

// File: aes_ctr/aes_ctr_ctrl.sv
// AES CTR request front end
// Four-phase req/ack handshake, opcode decode, sequencing of
// counter load and slice-wise increment

`timescale 1ns/1ns
`default_nettype none

module aes_ctr_ctrl (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  // Requester handshake
  input  logic                             req_i,
  input  aes_ctr_pkg::ctr_req_t            req_data_i,
  output logic                             ack_o,

  // Storage load
  output logic                             load_o,
  output logic [aes_ctr_pkg::CtrWidth-1:0] load_data_o,

  // Increment FSM
  output logic                             incr_o,
  input  logic                             ready_i,
  output logic                             incr_err_o,
  input  logic                             alert_i
);

  import aes_ctr_pkg::*;

  // Handshake states
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    WAIT_BUSY = 3'd1,
    WAIT_DONE = 3'd2,
    ACK       = 3'd3,
    RELEASE   = 3'd4
  } ctrl_state_e;

  ctrl_state_e state_d, state_q;

  // Load data taken straight from the held request
  assign load_data_o = req_data_i.data;

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    load_o     = 1'b0;
    incr_o     = 1'b0;
    incr_err_o = 1'b0;
    state_d    = state_q;

    case (state_q)
      IDLE: begin
        // Alert blocks every new request
        if (req_i && !alert_i) begin
          case (req_data_i.op)
            CTR_OP_LOAD: begin
              // Write lands on the same edge ack rises
              load_o  = 1'b1;
              state_d = ACK;
            end
            CTR_OP_INCR: begin
              // Only start when the FSM can take it
              if (ready_i) begin
                incr_o  = 1'b1;
                state_d = WAIT_BUSY;
              end
            end
            default: begin
              // Illegal opcode, stay parked here
              incr_err_o = 1'b1;
            end
          endcase
        end
      end

      // FSM leaves ready
      WAIT_BUSY: if (!ready_i) state_d = WAIT_DONE;

      // FSM back to ready, all slices written
      WAIT_DONE: if (ready_i) state_d = ACK;

      // Hold ack until requester lets go
      ACK: if (!req_i) state_d = RELEASE;

      // One guard cycle before the next request
      RELEASE: state_d = IDLE;

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Ack decoded from the state flop, glitch free
  assign ack_o = (state_q == ACK);

endmodule

`default_nettype wire

// File: rtl/aes_ctr_top.sv
// AES CTR block counter top level
// Joins handshake front end, slice storage and increment FSM

`timescale 1ns/1ns
`default_nettype none

module aes_ctr_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // Requester side
  input  logic                  req_i,
  input  aes_ctr_pkg::ctr_req_t req_data_i,
  output logic                  ack_o,
  output aes_ctr_pkg::ctr_rsp_t rsp_o
);

  import aes_ctr_pkg::*;

  // Front end to storage
  logic                     load;
  logic [CtrWidth-1:0]      load_data;
  // Front end to FSM
  logic                     incr;
  logic                     ready;
  logic                     incr_err;
  logic                     alert;
  // FSM to storage
  logic [SliceIdxWidth-1:0] slice_idx;
  logic                     slice_we;
  logic [SliceSizeCtr-1:0]  slice_wdata;
  logic [SliceSizeCtr-1:0]  slice_rdata;
  logic [CtrWidth-1:0]      ctr;

  ////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////

  aes_ctr_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .req_data_i  (req_data_i),
    .ack_o       (ack_o),
    .load_o      (load),
    .load_data_o (load_data),
    .incr_o      (incr),
    .ready_i     (ready),
    .incr_err_o  (incr_err),
    .alert_i     (alert)
  );

  aes_ctr_slices u_slices (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .load_i      (load),
    .load_data_i (load_data),
    .slice_idx_i (slice_idx),
    .slice_we_i  (slice_we),
    .slice_i     (slice_wdata),
    .slice_o     (slice_rdata),
    .ctr_o       (ctr)
  );

  aes_ctr_fsm u_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .incr_i          (incr),
    .ready_o         (ready),
    .incr_err_i      (incr_err),
    .alert_o         (alert),
    .ctr_slice_idx_o (slice_idx),
    .ctr_slice_i     (slice_rdata),
    .ctr_slice_o     (slice_wdata),
    .ctr_we_o        (slice_we)
  );

  // Response from storage and FSM
  assign rsp_o.ctr   = ctr;
  assign rsp_o.alert = alert;

endmodule

`default_nettype wire

// File: bench/aes_ctr_tb.sv
// AES CTR block counter testbench
// Table of loads and increment counts applied over the four-phase
// req/ack handshake, expected counter checked after each row

`timescale 1ns/1ns
`default_nettype none

module aes_ctr_tb;

  import aes_ctr_pkg::*;

  // One stimulus row with its expected counter
  typedef struct packed {
    logic [1:0]          op;
    logic [CtrWidth-1:0] load;
    logic [1:0]          incr_cnt;
    logic [CtrWidth-1:0] expected;
  } row_t;

  logic     clk_i;
  logic     rst_ni;
  logic     req_i;
  ctr_req_t req_data;
  logic     ack_o;
  ctr_rsp_t rsp_o;

  row_t        rows[$];
  integer      seed;
  // Cycles allowed per wait
  int unsigned wait_limit = 50;

  aes_ctr_top DUT (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .req_data_i (req_data),
    .ack_o      (ack_o),
    .rsp_o      (rsp_o)
  );

  // 20 ns clock
  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_ctr(input logic [CtrWidth-1:0] expected,
                           input logic [CtrWidth-1:0] actual);
    assert (actual == expected)
      else abort_run($sformatf("Error: rsp_o.ctr expected %h actual %h", expected, actual));
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    assert (actual == expected)
      else abort_run($sformatf("Error: %s expected %h actual %h", name, expected, actual));
  endtask

  ////////////////////////////////////////
  // Table and handshake
  ////////////////////////////////////////

  // Expected value is load plus count modulo 2**128
  task automatic add_row(input logic [1:0] op, input logic [CtrWidth-1:0] load,
                         input logic [1:0] cnt);
    row_t r;
    r.op       = op;
    r.load     = load;
    r.incr_cnt = cnt;
    r.expected = load + CtrWidth'(cnt);
    rows.push_back(r);
  endtask

  // One full four-phase transfer with the counter checked while ack is high
  task automatic transfer(input logic [1:0] op, input logic [CtrWidth-1:0] data,
                          input logic [CtrWidth-1:0] expected);
    int unsigned cycles;
    @(negedge clk_i);
    req_data.op   = ctr_op_e'(op);
    req_data.data = data;
    req_i         = 1'b1;
    cycles        = 0;
    while (!ack_o && cycles < wait_limit) begin
      @(negedge clk_i);
      cycles++;
    end
    assert (ack_o) else abort_run("ack_o did not rise within the timeout after req_i");
    check_ctr(expected, rsp_o.ctr);
    // Requester holds req one more cycle
    @(negedge clk_i);
    check_flag("ack_o", 1'b1, ack_o);
    check_ctr(expected, rsp_o.ctr);
    req_i  = 1'b0;
    cycles = 0;
    while (ack_o && cycles < wait_limit) begin
      @(negedge clk_i);
      cycles++;
    end
    assert (!ack_o) else abort_run("ack_o did not fall within the timeout after req_i dropped");
  endtask

  // Illegal opcode followed by a legal request that is never acknowledged
  task automatic check_illegal(input logic [1:0] op, input logic [CtrWidth-1:0] ctr_before);
    int unsigned cycles;
    @(negedge clk_i);
    req_data.op   = ctr_op_e'(op);
    req_data.data = '1;
    req_i         = 1'b1;
    cycles        = 0;
    while (!rsp_o.alert && cycles < wait_limit) begin
      @(negedge clk_i);
      check_flag("ack_o", 1'b0, ack_o);
      cycles++;
    end
    assert (rsp_o.alert) else abort_run("rsp_o.alert did not rise after an illegal opcode");
    req_i = 1'b0;
    @(negedge clk_i);
    req_data.op   = CTR_OP_INCR;
    req_data.data = '0;
    req_i         = 1'b1;
    for (cycles = 0; cycles < wait_limit; cycles++) begin
      @(negedge clk_i);
      check_flag("ack_o", 1'b0, ack_o);
      check_flag("rsp_o.alert", 1'b1, rsp_o.alert);
    end
    req_i = 1'b0;
    // Counter untouched by the refused requests
    check_ctr(ctr_before, rsp_o.ctr);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    logic [CtrWidth-1:0] last_expected;
    int unsigned         n_incr;
    int unsigned         k;
    row_t                row;

    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    req_i         = 1'b0;
    req_data      = '0;
    seed          = 32'haf53;
    last_expected = '0;

    // Fixed rows for carry across slices and full wrap
    add_row(CTR_OP_LOAD, 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210, 2'd0);
    add_row(CTR_OP_LOAD, {64'h0011_2233_4455_6677, 64'hffff_ffff_ffff_ffff}, 2'd1);
    add_row(CTR_OP_LOAD, '1, 2'd1);
    add_row(CTR_OP_LOAD, 128'h0000_0000_0000_0000_0000_0000_0000_fffe, 2'd3);
    // Random rows
    add_row(CTR_OP_LOAD, {$random(seed), $random(seed), $random(seed), $random(seed)}, 2'd1);
    add_row(CTR_OP_LOAD, {$random(seed), $random(seed), $random(seed), $random(seed)}, 2'd2);
    add_row(CTR_OP_LOAD, {$random(seed), $random(seed), $random(seed), $random(seed)}, 2'd3);
    add_row(CTR_OP_LOAD, {$random(seed), $random(seed), $random(seed), 32'hffff_ffff}, 2'd2);
    // Illegal opcode last since the alert is terminal
    add_row(2'b11, '0, 2'd0);

    // Reset for two cycles
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    @(negedge clk_i);
    check_flag("ack_o", 1'b0, ack_o);
    check_flag("rsp_o.alert", 1'b0, rsp_o.alert);
    check_ctr('0, rsp_o.ctr);

    foreach (rows[i]) begin
      row = rows[i];
      if (row.op == CTR_OP_LOAD) begin
        transfer(CTR_OP_LOAD, row.load, row.load);
        n_incr = 32'(row.incr_cnt);
        for (k = 0; k < n_incr; k++) begin
          transfer(CTR_OP_INCR, '0, row.load + CtrWidth'(k + 1));
        end
        // Counter holds the row result after the last release
        check_ctr(row.expected, rsp_o.ctr);
        check_flag("rsp_o.alert", 1'b0, rsp_o.alert);
        last_expected = row.expected;
      end else begin
        check_illegal(row.op, last_expected);
      end
    end

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: aes_ctr.f
common/aes_ctr_pkg.sv
aes_ctr/aes_ctr_fsm.sv
aes_ctr/aes_ctr_slices.sv
aes_ctr/aes_ctr_ctrl.sv
rtl/aes_ctr_top.sv
bench/aes_ctr_tb.sv

// File: Makefile
# Verilator build and run of the AES CTR block counter testbench

VERILATOR ?= verilator
TOP       ?= aes_ctr_tb
FILELIST  ?= aes_ctr.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
